/* Bender.yml */
package:
  name: park

sources:
  - parkPkg.sv
  - parkIf.sv
  - keyPad.sv
  - stallTable.sv
  - feeUnit.sv
  - parkCtrl.sv
  - dispOut.sv
  - parkTop.sv
  - target: test
    files:
      - parkTb.sv

/* dispOut.sv */
module dispOut import parkPkg::*; (
    input  logic      clk3,
    input  logic      enable,
    input  parkStateT state,
    input  moneyT     bill,
    input  moneyT     change,
    input  ticketT    ticket,
    input  moneyT     income,
    input  moneyT     entry,
    output dispModeT  displayMode,
    output msgT       message,
    output moneyT     showValue
);

    dispModeT modeNext;
    msgT      msgNext;
    moneyT    valueNext;

    always_comb begin
        modeNext  = ModeNumber;
        msgNext   = MsgTicket;
        valueNext = '0;
        case (state)
            StIdle:    modeNext = ModeIdleInfo;
            StTicket:  valueNext = ticket;
            StNoStall: begin
                modeNext = ModeMessage;
                msgNext  = MsgNoStall;
            end
            StEnterId: begin
                msgNext   = MsgEnterId;
                valueNext = entry;      // live keypad value
            end
            StPay: begin
                msgNext   = MsgPay;
                valueNext = bill;
            end
            StNoMoney: begin
                modeNext = ModeMessage;
                msgNext  = MsgNoMoney;
            end
            StChange: begin
                msgNext   = MsgChange;
                valueNext = change;
            end
            StAdmin: begin
                modeNext = ModeMessage;
                msgNext  = MsgAdmin;
            end
            StIncome: begin
                msgNext   = MsgIncome;
                valueNext = income;
            end
            StSetBase: begin
                msgNext   = MsgSetBase;
                valueNext = entry;
            end
            StSetRate: begin
                msgNext   = MsgSetRate;
                valueNext = entry;
            end
            default: modeNext = ModeBlank;
        endcase
    end

    always_ff @(posedge clk3 or negedge enable) begin
        if (!enable) begin
            displayMode <= ModeIdleInfo;
            message     <= MsgTicket;
            showValue   <= '0;
        end else begin
            displayMode <= modeNext;
            message     <= msgNext;
            showValue   <= valueNext;
        end
    end

endmodule

/* feeUnit.sv */
module feeUnit import parkPkg::*; #(
    parameter int HourTicks = DefHourTicks
) (
    input  logic  clk3,
    input  logic  enable,
    input  timeT  elapsed,
    input  moneyT entryValue,
    input  moneyT paid,
    input  logic  payReq,
    input  logic  setBase,
    input  logic  setRate,
    input  logic  clearIncome,
    output moneyT bill,
    output logic  enough,
    output moneyT income
);

    moneyT       baseFee;
    moneyT       hourRate;
    logic [8:0]  hours;        // started hours
    logic [16:0] billWide;

    assign hours    = 9'(elapsed / HourTicks) + 9'd1;
    assign billWide = 17'(baseFee) + 17'(hourRate) * 17'(hours);
    assign bill     = (billWide > 17'd255) ? 8'hff : billWide[7:0];   // saturate
    assign enough   = (paid >= bill);

    always_ff @(posedge clk3 or negedge enable) begin
        if (!enable) begin
            baseFee  <= DefBaseFee;
            hourRate <= DefHourRate;
            income   <= '0;
        end else begin
            if (setBase) baseFee <= entryValue;
            if (setRate) hourRate <= entryValue;
            if (clearIncome) begin
                income <= '0;
            end else if (payReq) begin
                income <= income + bill;    // wraps at 8 bits
            end
        end
    end

endmodule

/* keyPad.sv */
module keyPad import parkPkg::*; (
    input  logic   clk3,
    input  logic   enable,
    input  buttonT button,
    input  keyT    key,
    input  logic   finish,
    cmdIf.src      cmd
);

    logic   held;       // a button was down at the last sample
    logic   oneHot;
    buttonT press;

    assign oneHot = (button != '0) && ((button & (button - 1'b1)) == '0);

    always_ff @(posedge clk3 or negedge enable) begin
        if (!enable) begin
            held  <= 1'b0;
            press <= '0;
        end else begin
            held  <= |button;
            press <= (oneHot && !held) ? button : '0;    // rising edge only
        end
    end

    always_ff @(posedge clk3 or negedge enable) begin
        if (!enable) begin
            cmd.entry <= '0;
        end else if (finish) begin
            cmd.entry <= {key[9:6], key[3:0]};    // low nibble of each digit
        end
    end

    assign cmd.pressUp   = press[BtnUp];
    assign cmd.pressDown = press[BtnDown];
    assign cmd.pressOk   = press[BtnOk];
    assign cmd.pressBack = press[BtnBack];
    assign cmd.pressMid  = press[BtnMid];

    assert property (@(posedge clk3) disable iff (!enable)
        $onehot0({cmd.pressUp, cmd.pressDown, cmd.pressOk, cmd.pressBack, cmd.pressMid}));

endmodule

/* park.f */
parkPkg.sv
parkIf.sv
keyPad.sv
stallTable.sv
feeUnit.sv
parkCtrl.sv
dispOut.sv
parkTop.sv
parkTb.sv

/* parkCtrl.sv */
module parkCtrl import parkPkg::*; #(
    parameter int PayTimeout = DefPayTimeout
) (
    input  logic      clk3,
    input  logic      enable,
    cmdIf.dst         cmd,
    stallIf.ctrl      st,
    output timeT      elapsed,
    output moneyT     paid,
    output logic      payReq,
    output logic      setBase,
    output logic      setRate,
    output logic      clearIncome,
    output moneyT     entryValue,
    input  moneyT     bill,
    input  logic      enough,
    output parkStateT state,
    output moneyT     change,
    output ticketT    ticket
);

    localparam int CntW = $clog2(PayTimeout + 1);

    parkStateT       stateNext;
    logic [CntW-1:0] payCnt;
    logic            anyPress;
    logic            payTimeout;

    assign anyPress = cmd.pressUp | cmd.pressDown | cmd.pressOk | cmd.pressBack | cmd.pressMid;
    assign payTimeout = (payCnt == CntW'(PayTimeout - 1)) && !anyPress;

    assign elapsed    = st.elapsed;
    assign paid       = cmd.entry;
    assign entryValue = cmd.entry;

    //////////////////////////////////////////////////
    // commands, taken at the press edge
    assign st.allocReq   = (state == StIdle) && cmd.pressOk && st.anyFree;
    assign st.releaseReq = (state == StPay) && cmd.pressOk && enough;
    assign payReq        = st.releaseReq;
    assign clearIncome   = (state == StIncome) && cmd.pressMid;
    assign setBase       = (state == StSetBase) && cmd.pressOk;
    assign setRate       = (state == StSetRate) && cmd.pressOk;
    assign st.lookupId   = (state == StEnterId) ? cmd.entry : ticket;   // hold id after lookup

    //////////////////////////////////////////////////
    // next state
    always_comb begin
        stateNext = state;
        case (state)
            StIdle: begin
                if (cmd.pressOk) stateNext = st.anyFree ? StTicket : StNoStall;
                else if (cmd.pressBack) stateNext = StEnterId;
                else if (cmd.pressDown) stateNext = StAdmin;
            end
            StEnterId: begin
                if (cmd.pressOk) stateNext = st.hit ? StPay : StIdle;
                else if (cmd.pressBack) stateNext = StIdle;
            end
            StPay: begin
                if (cmd.pressOk) stateNext = enough ? StChange : StNoMoney;
                else if (cmd.pressBack || payTimeout) stateNext = StIdle;
            end
            StTicket, StNoStall, StChange: begin
                if (cmd.pressOk || cmd.pressBack) stateNext = StIdle;
            end
            StNoMoney: begin
                if (cmd.pressOk || cmd.pressBack) stateNext = StPay;   // try again
            end
            StAdmin: begin
                if (cmd.pressUp) stateNext = StIncome;
                else if (cmd.pressBack) stateNext = StIdle;
            end
            StIncome: begin
                if (cmd.pressUp) stateNext = StSetBase;
                else if (cmd.pressDown) stateNext = StSetRate;
                else if (cmd.pressBack) stateNext = StAdmin;
            end
            StSetBase, StSetRate: begin
                if (cmd.pressOk || cmd.pressBack) stateNext = StIncome;
            end
            default: stateNext = StIdle;
        endcase
    end

    always_ff @(posedge clk3 or negedge enable) begin
        if (!enable) begin
            state  <= StIdle;
            payCnt <= '0;
            ticket <= '0;
        end else begin
            state <= stateNext;
            if (state == StPay && !anyPress) begin
                payCnt <= payCnt + 1'b1;
            end else begin
                payCnt <= '0;   // cleared outside Pay and on any key
            end
            if (st.allocReq) begin
                ticket <= st.newTicket;
            end else if (state == StEnterId && cmd.pressOk && st.hit) begin
                ticket <= cmd.entry;
            end
        end
    end

    always_ff @(posedge clk3) begin
        if (st.releaseReq) change <= paid - bill;
    end

    // release needs a matched stall
    assert property (@(posedge clk3) disable iff (!enable)
        st.releaseReq |-> (state == StPay) && st.hit);

endmodule

/* parkIf.sv */
interface cmdIf import parkPkg::*; ();

    logic  pressUp;
    logic  pressDown;
    logic  pressOk;
    logic  pressBack;
    logic  pressMid;
    moneyT entry;       // value latched on finish

    modport src (output pressUp, pressDown, pressOk, pressBack, pressMid, entry);
    modport dst (input pressUp, pressDown, pressOk, pressBack, pressMid, entry);

endinterface

interface stallIf import parkPkg::*; ();

    logic       allocReq;
    ticketT     lookupId;
    logic       releaseReq;     // frees the stall of the last hit
    logic       anyFree;
    logic [2:0] freeCount;
    ticketT     newTicket;
    logic       hit;
    timeT       elapsed;

    modport ctrl (
        output allocReq, lookupId, releaseReq,
        input  anyFree, freeCount, newTicket, hit, elapsed
    );
    modport tbl (
        input  allocReq, lookupId, releaseReq,
        output anyFree, freeCount, newTicket, hit, elapsed
    );

endinterface

/* parkPkg.sv */
package parkPkg;

    typedef logic [7:0]  moneyT;    // fees, bills, change, income
    typedef logic [7:0]  ticketT;   // 0 = no ticket
    typedef logic [7:0]  timeT;     // tick count
    typedef logic [11:0] keyT;      // two 6-bit digit codes
    typedef logic [4:0]  buttonT;   // one-hot buttons

    // bit positions in buttonT
    localparam int BtnUp   = 0;
    localparam int BtnDown = 1;
    localparam int BtnOk   = 2;
    localparam int BtnBack = 3;
    localparam int BtnMid  = 4;

    typedef enum logic [1:0] {
        ModeBlank,
        ModeIdleInfo,
        ModeMessage,
        ModeNumber
    } dispModeT;

    typedef enum logic [3:0] {
        MsgTicket,
        MsgNoStall,
        MsgEnterId,
        MsgPay,
        MsgNoMoney,
        MsgChange,
        MsgAdmin,
        MsgIncome,
        MsgSetBase,
        MsgSetRate
    } msgT;

    typedef enum logic [3:0] {
        StIdle,
        StTicket,
        StNoStall,
        StEnterId,
        StPay,
        StNoMoney,
        StChange,
        StAdmin,
        StIncome,
        StSetBase,
        StSetRate
    } parkStateT;

    localparam int    DefNumStalls  = 4;
    localparam int    DefTickDiv    = 16;     // cycles per tick
    localparam int    DefHourTicks  = 8;      // ticks per hour
    localparam int    DefPayTimeout = 2000;   // cycles
    localparam moneyT DefBaseFee    = 8'd1;
    localparam moneyT DefHourRate   = 8'd1;

endpackage

/* parkTb.sv */
module parkTb import parkPkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int Stalls       = 4;
    localparam int TickDivTb    = 4;
    localparam int HourTicksTb  = 8;
    localparam int PayTimeoutTb = 200;
    localparam int CycleLimit   = 20000;     // tests need about 2500 cycles

    logic       clk3 = 1'b0;
    logic       enable;
    buttonT     button;
    keyT        key;
    logic       finish;
    dispModeT   displayMode;
    msgT        message;
    moneyT      showValue;
    logic [2:0] freeCount;

    bit     occ [Stalls];          // model occupancy
    int     entryCyc [Stalls];     // cycle when Ok was pressed for entry
    int     income   = 0;
    int     baseFee  = DefBaseFee;
    int     hourRate = DefHourRate;
    int     errors   = 0;
    int     cycleCnt = 0;
    integer seed     = 67;

    parkTop #(.NumStalls(Stalls), .TickDiv(TickDivTb), .HourTicks(HourTicksTb),
              .PayTimeout(PayTimeoutTb)) DUT (
        .clk3(clk3), .enable(enable), .button(button), .key(key), .finish(finish),
        .displayMode(displayMode), .message(message), .showValue(showValue),
        .freeCount(freeCount)
    );

    always #10 clk3 = ~clk3;

    always @(posedge clk3) begin
        cycleCnt++;
        if (cycleCnt >= CycleLimit) begin
            $display("run stopped at the cycle limit of %0d", CycleLimit);
            $display("errors: %0d", errors);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // helpers
    function automatic int randBelow(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic int sat(input int v);
        return (v > 255) ? 255 : v;
    endfunction

    function automatic int fee(input int ticks);
        return sat(baseFee + hourRate * (ticks / HourTicksTb + 1));
    endfunction

    function automatic int freeModel();
        int n;
        n = 0;
        for (int k = 0; k < Stalls; k++) n += !occ[k];
        return n;
    endfunction

    function automatic int lowestFree();
        for (int k = 0; k < Stalls; k++) if (!occ[k]) return k;
        return -1;
    endfunction

    task automatic checkValue(input string name, input int got, input int exp);
        assert (got == exp) else begin
            errors++;
            $display("[FAIL] %s got %0h expected %0h", name, got, exp);
        end
    endtask

    task automatic checkScreen(input dispModeT mode, input msgT msg);
        checkValue("displayMode", displayMode, mode);
        if (mode != ModeIdleInfo) checkValue("message", message, msg);
    endtask

    task automatic press(input int idx);
        button = buttonT'(1 << idx);
        @(negedge clk3);
        button = '0;
        repeat (4) @(negedge clk3);     // display settles meanwhile
    endtask

    task automatic enterValue(input moneyT v);
        key    = {2'b00, v[7:4], 2'b00, v[3:0]};
        finish = 1'b1;
        @(negedge clk3);
        finish = 1'b0;
        @(negedge clk3);
    endtask

    //////////////////////////////////////////////////
    // scenarios
    task automatic parkCar();
        int idx;
        int startCyc;
        idx      = lowestFree();
        startCyc = cycleCnt;
        press(BtnOk);
        if (idx >= 0) begin
            occ[idx]      = 1'b1;
            entryCyc[idx] = startCyc;
            checkScreen(ModeNumber, MsgTicket);
            checkValue("showValue", showValue, idx + 1);
        end else begin
            checkScreen(ModeMessage, MsgNoStall);
        end
        checkValue("freeCount", freeCount, freeModel());
        press(BtnOk);
    endtask

    // mode 0 pays enough, 1 pays too little, 2 waits for the timeout
    task automatic leaveCar(input int tkt, input int mode);
        int idx;
        int lo;
        int minB;
        int shown;
        int paid;
        int billUsed;
        int waitCnt;
        press(BtnBack);
        checkScreen(ModeNumber, MsgEnterId);
        enterValue(moneyT'(tkt));
        press(BtnOk);
        idx = tkt - 1;
        if (tkt < 1 || tkt > Stalls || !occ[idx]) begin
            checkScreen(ModeIdleInfo, MsgTicket);
            checkValue("freeCount", freeCount, freeModel());
            return;
        end
        checkScreen(ModeNumber, MsgPay);
        shown = showValue;
        lo    = (cycleCnt - entryCyc[idx] > 8) ? (cycleCnt - entryCyc[idx] - 8) / TickDivTb : 0;
        minB  = fee(lo);
        assert (shown >= minB && shown <= sat(minB + hourRate)) else begin
            errors++;
            $display("[FAIL] showValue got %0h expected %0h to %0h", shown, minB,
                     sat(minB + hourRate));
        end
        if (mode == 2) begin
            waitCnt = 0;
            while (displayMode != ModeIdleInfo && waitCnt < PayTimeoutTb + 20) begin
                @(negedge clk3);
                waitCnt++;
            end
            assert (displayMode == ModeIdleInfo && waitCnt > PayTimeoutTb - 20) else begin
                errors++;
                $display("Pay screen did not time out as expected, waited %0d cycles", waitCnt);
            end
        end else if (mode == 0) begin
            paid = sat(shown + hourRate + randBelow(8));    // covers one more hour
            enterValue(moneyT'(paid));
            press(BtnOk);
            checkScreen(ModeNumber, MsgChange);
            billUsed = (paid - showValue) & 8'hff;
            assert (billUsed == shown || billUsed == sat(shown + hourRate)) else begin
                errors++;
                $display("[FAIL] showValue got %0h expected %0h", showValue, paid - shown);
            end
            occ[idx] = 1'b0;
            income   = (income + billUsed) % 256;
            checkValue("freeCount", freeCount, freeModel());
            press(BtnOk);
        end else begin
            paid = shown - 1 - randBelow(shown - 1);
            enterValue(moneyT'(paid));
            press(BtnOk);
            checkScreen(ModeMessage, MsgNoMoney);
            press(BtnBack);     // back to Pay
            press(BtnBack);
        end
        checkScreen(ModeIdleInfo, MsgTicket);
        checkValue("freeCount", freeCount, freeModel());
    endtask

    task automatic clearAll();
        for (int k = 0; k < Stalls; k++) if (occ[k]) leaveCar(k + 1, 0);
    endtask

    task automatic openIncome();
        press(BtnDown);
        checkScreen(ModeMessage, MsgAdmin);
        press(BtnUp);
        checkScreen(ModeNumber, MsgIncome);
        checkValue("showValue", showValue, income);
    endtask

    task automatic closeIncome();
        press(BtnBack);
        press(BtnBack);
        checkScreen(ModeIdleInfo, MsgTicket);
    endtask

    task automatic setTariffs(input int newBase, input int newRate);
        openIncome();
        press(BtnUp);
        checkScreen(ModeNumber, MsgSetBase);
        enterValue(moneyT'(newBase));
        press(BtnOk);
        press(BtnDown);
        checkScreen(ModeNumber, MsgSetRate);
        enterValue(moneyT'(newRate));
        press(BtnOk);
        checkScreen(ModeNumber, MsgIncome);
        baseFee  = newBase;
        hourRate = newRate;
        press(BtnMid);      // clears income
        income = 0;
        checkValue("showValue", showValue, 0);
        closeIncome();
    endtask

    task automatic randomOp();
        int r;
        int tkt;
        int mode;
        r    = randBelow(8);
        tkt  = (randBelow(4) == 0) ? randBelow(256) : randBelow(Stalls) + 1;
        mode = randBelow(2);
        if (r < 3) parkCar();
        else leaveCar(tkt, mode);
    endtask

    initial begin
        button = '0;
        key    = '0;
        finish = 1'b0;
        enable = 1'b0;
        repeat (5) @(negedge clk3);
        enable = 1'b1;
        @(negedge clk3);
        checkScreen(ModeIdleInfo, MsgTicket);
        checkValue("freeCount", freeCount, Stalls);
        openIncome();
        closeIncome();
        repeat (Stalls + 1) parkCar();     // last one finds no stall
        leaveCar(Stalls + 5, 0);
        leaveCar(2, 2);
        clearAll();
        repeat (30) randomOp();
        clearAll();
        setTariffs(randBelow(8) + 2, randBelow(8) + 2);    // both above the defaults
        repeat (30) randomOp();
        clearAll();
        openIncome();
        closeIncome();
        $display("errors: %0d", errors);
        if (errors == 0) $display("STATUS: PASS");
        else $display("STATUS: FAIL");
        $finish;
    end

endmodule

/* parkTop.sv */
module parkTop import parkPkg::*; #(
    parameter int NumStalls  = DefNumStalls,
    parameter int TickDiv    = DefTickDiv,
    parameter int HourTicks  = DefHourTicks,
    parameter int PayTimeout = DefPayTimeout
) (
    input  logic       clk3,
    input  logic       enable,
    input  buttonT     button,
    input  keyT        key,
    input  logic       finish,
    output dispModeT   displayMode,
    output msgT        message,
    output moneyT      showValue,
    output logic [2:0] freeCount
);

    cmdIf   cmdBus ();
    stallIf stallBus ();

    timeT      elapsed;
    moneyT     paid;
    moneyT     entryValue;
    moneyT     bill;
    moneyT     income;
    moneyT     change;
    logic      enough;
    logic      payReq;
    logic      setBase;
    logic      setRate;
    logic      clearIncome;
    parkStateT state;
    ticketT    ticket;

    assign freeCount = stallBus.freeCount;

    keyPad uKeyPad (
        .clk3(clk3), .enable(enable), .button(button), .key(key), .finish(finish),
        .cmd(cmdBus.src)
    );

    stallTable #(.NumStalls(NumStalls), .TickDiv(TickDiv)) uStallTable (
        .clk3(clk3), .enable(enable), .st(stallBus.tbl)
    );

    feeUnit #(.HourTicks(HourTicks)) uFeeUnit (
        .clk3(clk3), .enable(enable), .elapsed(elapsed), .entryValue(entryValue),
        .paid(paid), .payReq(payReq), .setBase(setBase), .setRate(setRate),
        .clearIncome(clearIncome), .bill(bill), .enough(enough), .income(income)
    );

    parkCtrl #(.PayTimeout(PayTimeout)) uParkCtrl (
        .clk3(clk3), .enable(enable), .cmd(cmdBus.dst), .st(stallBus.ctrl),
        .elapsed(elapsed), .paid(paid), .payReq(payReq), .setBase(setBase),
        .setRate(setRate), .clearIncome(clearIncome), .entryValue(entryValue),
        .bill(bill), .enough(enough), .state(state), .change(change), .ticket(ticket)
    );

    dispOut uDispOut (
        .clk3(clk3), .enable(enable), .state(state), .bill(bill), .change(change),
        .ticket(ticket), .income(income), .entry(cmdBus.entry),
        .displayMode(displayMode), .message(message), .showValue(showValue)
    );

endmodule

/* stallTable.sv */
module stallTable import parkPkg::*; #(
    parameter int NumStalls = DefNumStalls,
    parameter int TickDiv   = DefTickDiv
) (
    input  logic clk3,
    input  logic enable,
    stallIf.tbl  st
);

    localparam int DivW = (TickDiv > 1) ? $clog2(TickDiv) : 1;
    localparam int IdxW = (NumStalls > 1) ? $clog2(NumStalls) : 1;

    logic [DivW-1:0]      divCnt;
    timeT                 nowTime;
    logic [NumStalls-1:0] occupied;
    timeT                 entryTime [NumStalls];
    logic [IdxW-1:0]      freeIdx;
    logic [2:0]           freeNum;
    logic [IdxW-1:0]      hitIdx;
    logic                 hit;
    logic [IdxW-1:0]      matchIdx;    // stall of the last hit

    //////////////////////////////////////////////////
    // time base
    always_ff @(posedge clk3 or negedge enable) begin
        if (!enable) begin
            divCnt  <= '0;
            nowTime <= '0;
        end else if (divCnt == DivW'(TickDiv - 1)) begin
            divCnt  <= '0;
            nowTime <= nowTime + 1'b1;
        end else begin
            divCnt <= divCnt + 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // allocation and lookup
    always_comb begin
        freeIdx = '0;
        freeNum = '0;
        for (int k = NumStalls - 1; k >= 0; k--) begin
            if (!occupied[k]) begin
                freeIdx = IdxW'(k);     // ends on the lowest
                freeNum = freeNum + 1'b1;
            end
        end
    end

    always_comb begin
        hitIdx = '0;
        hit    = 1'b0;
        for (int k = 0; k < NumStalls; k++) begin
            if (occupied[k] && st.lookupId == ticketT'(k + 1)) begin
                hitIdx = IdxW'(k);
                hit    = 1'b1;
            end
        end
    end

    assign st.anyFree   = (freeNum != '0);
    assign st.freeCount = freeNum;
    assign st.newTicket = ticketT'(freeIdx) + 1'b1;
    assign st.hit       = hit;
    assign st.elapsed   = hit ? nowTime - entryTime[hitIdx] : '0;

    always_ff @(posedge clk3 or negedge enable) begin
        if (!enable) begin
            occupied <= '0;
        end else begin
            if (st.allocReq) occupied[freeIdx] <= 1'b1;
            if (st.releaseReq) occupied[matchIdx] <= 1'b0;
        end
    end

    always_ff @(posedge clk3) begin
        if (st.allocReq) entryTime[freeIdx] <= nowTime;
        if (hit) matchIdx <= hitIdx;
    end

    assert property (@(posedge clk3) disable iff (!enable) st.allocReq |-> st.anyFree);

endmodule
